// File: include/soc_bus_settings.svh
`ifndef SOC_BUS_SETTINGS_SVH
`define SOC_BUS_SETTINGS_SVH

// bus widths
`define SOC_BUS_ADDR_W 32
`define SOC_BUS_DATA_W 32

// serial transmit data register
`define SOC_BUS_SERIAL_ADDR 32'h1000_0000

// mtime is read as two words, low then high
`define SOC_BUS_RTC_ADDR    32'hA000_0048
`define SOC_BUS_RTC_ADDR_UP 32'hA000_004C

// clocks per serial bit
`define SOC_BUS_UART_DIV 4

// clocks per mtime increment
`define SOC_BUS_MTIME_DIV 2

`endif

// File: hdl/soc_bus_pkg.sv
package soc_bus_pkg;

  // device that serves the current transaction
  typedef enum logic [1:0] {
    EXT   = 2'd0,
    CLINT = 2'd1,
    UART  = 2'd2
  } target_e;

  // arbiter transaction FSM
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    RD_ADDR = 3'd1,
    RD_DATA = 3'd2,
    WR_ADDR = 3'd3,
    WR_RESP = 3'd4
  } arb_state_e;

  // AXI response codes, EXOKAY is never produced here
  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2,
    DECERR = 2'd3
  } resp_e;

endpackage

// File: hdl/axi_lite_if.sv
`timescale 1ns/1ns
`include "soc_bus_settings.svh"

interface axi_lite_if;

  // write address
  logic                          awvalid;
  logic                          awready;
  logic [`SOC_BUS_ADDR_W-1:0]    awaddr;

  // write data
  logic                          wvalid;
  logic                          wready;
  logic [`SOC_BUS_DATA_W-1:0]    wdata;
  logic [`SOC_BUS_DATA_W/8-1:0]  wstrb;

  // write response
  logic                          bvalid;
  logic                          bready;
  logic [1:0]                    bresp;

  // read address
  logic                          arvalid;
  logic                          arready;
  logic [`SOC_BUS_ADDR_W-1:0]    araddr;

  // read data
  logic                          rvalid;
  logic                          rready;
  logic [`SOC_BUS_DATA_W-1:0]    rdata;
  logic [1:0]                    rresp;

  modport master (
    output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

  modport slave (
    input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

endinterface

// File: hdl/bus_arbiter.sv
`timescale 1ns/1ns
`include "soc_bus_settings.svh"

module bus_arbiter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [`SOC_BUS_ADDR_W-1:0]    ifu_araddr_i,
  input  logic                          ifu_arvalid_i,
  input  logic [`SOC_BUS_ADDR_W-1:0]    lsu_araddr_i,
  input  logic                          lsu_arvalid_i,
  input  logic [`SOC_BUS_ADDR_W-1:0]    lsu_awaddr_i,
  input  logic [`SOC_BUS_DATA_W-1:0]    lsu_wdata_i,
  input  logic [`SOC_BUS_DATA_W/8-1:0]  lsu_wstrb_i,
  input  logic                          lsu_wvalid_i,
  output logic [`SOC_BUS_DATA_W-1:0]    ifu_rdata_o,
  output logic                          ifu_rvalid_o,
  output logic                          ifu_err_o,
  output logic [`SOC_BUS_DATA_W-1:0]    lsu_rdata_o,
  output logic                          lsu_rvalid_o,
  output logic                          lsu_wready_o,
  output logic                          lsu_err_o,
  axi_lite_if.master                    ext,
  axi_lite_if.master                    clint_bus,
  axi_lite_if.master                    uart_bus
);

  soc_bus_pkg::arb_state_e       state_q;
  soc_bus_pkg::target_e          target_q;
  soc_bus_pkg::target_e          rd_target;
  logic                          rd_ifu_q;
  logic                          aw_pend_q;
  logic                          w_pend_q;
  logic [`SOC_BUS_ADDR_W-1:0]    addr_q;
  logic [`SOC_BUS_DATA_W-1:0]    wdata_q;
  logic [`SOC_BUS_DATA_W/8-1:0]  wstrb_q;
  logic [`SOC_BUS_DATA_W-1:0]    rdata_q;
  logic                          err_q;
  logic                          ifu_done_q;
  logic                          lsu_rd_done_q;
  logic                          lsu_wr_done_q;
  logic                          done_any;
  logic                          accept;
  logic [`SOC_BUS_ADDR_W-1:0]    rd_addr;
  logic                          aw_left;
  logic                          w_left;

  // response side of the selected device
  logic                          arready_sel;
  logic                          rvalid_sel;
  logic [`SOC_BUS_DATA_W-1:0]    rdata_sel;
  logic [1:0]                    rresp_sel;
  logic                          awready_sel;
  logic                          wready_sel;
  logic                          bvalid_sel;
  logic [1:0]                    bresp_sel;

  // the requester still holds valid during its done pulse, so skip that cycle
  assign done_any = ifu_done_q | lsu_rd_done_q | lsu_wr_done_q;
  assign accept   = (state_q == soc_bus_pkg::IDLE) && !done_any &&
                    (lsu_wvalid_i || lsu_arvalid_i || ifu_arvalid_i);

  // lsu load beats fetch
  assign rd_addr   = lsu_arvalid_i ? lsu_araddr_i : ifu_araddr_i;
  assign rd_target = (rd_addr == `SOC_BUS_RTC_ADDR || rd_addr == `SOC_BUS_RTC_ADDR_UP) ?
                     soc_bus_pkg::CLINT : soc_bus_pkg::EXT;

  always_comb
  begin
    arready_sel = ext.arready;
    rvalid_sel  = ext.rvalid;
    rdata_sel   = ext.rdata;
    rresp_sel   = ext.rresp;
    awready_sel = ext.awready;
    wready_sel  = ext.wready;
    bvalid_sel  = ext.bvalid;
    bresp_sel   = ext.bresp;
    case (target_q)
      soc_bus_pkg::CLINT:
      begin
        arready_sel = clint_bus.arready;
        rvalid_sel  = clint_bus.rvalid;
        rdata_sel   = clint_bus.rdata;
        rresp_sel   = clint_bus.rresp;
      end
      soc_bus_pkg::UART:
      begin
        awready_sel = uart_bus.awready;
        wready_sel  = uart_bus.wready;
        bvalid_sel  = uart_bus.bvalid;
        bresp_sel   = uart_bus.bresp;
      end
      default:
      begin
      end
    endcase
  end

  // aw and w each drop on their own handshake
  assign aw_left = aw_pend_q && !awready_sel;
  assign w_left  = w_pend_q && !wready_sel;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q       <= soc_bus_pkg::IDLE;
      target_q      <= soc_bus_pkg::EXT;
      rd_ifu_q      <= 1'b0;
      aw_pend_q     <= 1'b0;
      w_pend_q      <= 1'b0;
      err_q         <= 1'b0;
      ifu_done_q    <= 1'b0;
      lsu_rd_done_q <= 1'b0;
      lsu_wr_done_q <= 1'b0;
    end
    else
    begin
      ifu_done_q    <= 1'b0;
      lsu_rd_done_q <= 1'b0;
      lsu_wr_done_q <= 1'b0;
      case (state_q)
        soc_bus_pkg::IDLE:
        begin
          if (accept && lsu_wvalid_i)
          begin
            state_q   <= soc_bus_pkg::WR_ADDR;
            target_q  <= (lsu_awaddr_i == `SOC_BUS_SERIAL_ADDR) ?
                         soc_bus_pkg::UART : soc_bus_pkg::EXT;
            aw_pend_q <= 1'b1;
            w_pend_q  <= 1'b1;
          end
          else if (accept)
          begin
            state_q  <= soc_bus_pkg::RD_ADDR;
            target_q <= rd_target;
            rd_ifu_q <= !lsu_arvalid_i;
          end
        end
        soc_bus_pkg::RD_ADDR:
        begin
          if (arready_sel)
            state_q <= soc_bus_pkg::RD_DATA;
        end
        soc_bus_pkg::RD_DATA:
        begin
          if (rvalid_sel)
          begin
            state_q       <= soc_bus_pkg::IDLE;
            err_q         <= (rresp_sel != soc_bus_pkg::OKAY);
            ifu_done_q    <= rd_ifu_q;
            lsu_rd_done_q <= !rd_ifu_q;
          end
        end
        soc_bus_pkg::WR_ADDR:
        begin
          aw_pend_q <= aw_left;
          w_pend_q  <= w_left;
          if (!aw_left && !w_left)
            state_q <= soc_bus_pkg::WR_RESP;
        end
        soc_bus_pkg::WR_RESP:
        begin
          if (bvalid_sel)
          begin
            state_q       <= soc_bus_pkg::IDLE;
            err_q         <= (bresp_sel != soc_bus_pkg::OKAY);
            lsu_wr_done_q <= 1'b1;
          end
        end
        default:
          state_q <= soc_bus_pkg::IDLE;
      endcase
    end
  end

  // transaction payload
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      addr_q  <= lsu_wvalid_i ? lsu_awaddr_i : rd_addr;
      wdata_q <= lsu_wdata_i;
      wstrb_q <= lsu_wstrb_i;
    end
    if (state_q == soc_bus_pkg::RD_DATA && rvalid_sel)
      rdata_q <= rdata_sel;
  end

  // external memory port
  assign ext.awvalid = (state_q == soc_bus_pkg::WR_ADDR) && aw_pend_q &&
                       (target_q == soc_bus_pkg::EXT);
  assign ext.awaddr  = addr_q;
  assign ext.wvalid  = (state_q == soc_bus_pkg::WR_ADDR) && w_pend_q &&
                       (target_q == soc_bus_pkg::EXT);
  assign ext.wdata   = wdata_q;
  assign ext.wstrb   = wstrb_q;
  assign ext.bready  = (state_q == soc_bus_pkg::WR_RESP) && (target_q == soc_bus_pkg::EXT);
  assign ext.arvalid = (state_q == soc_bus_pkg::RD_ADDR) && (target_q == soc_bus_pkg::EXT);
  assign ext.araddr  = addr_q;
  assign ext.rready  = (state_q == soc_bus_pkg::RD_DATA) && (target_q == soc_bus_pkg::EXT);

  // timer is read only
  assign clint_bus.awvalid = 1'b0;
  assign clint_bus.awaddr  = '0;
  assign clint_bus.wvalid  = 1'b0;
  assign clint_bus.wdata   = '0;
  assign clint_bus.wstrb   = '0;
  assign clint_bus.bready  = 1'b0;
  assign clint_bus.arvalid = (state_q == soc_bus_pkg::RD_ADDR) &&
                             (target_q == soc_bus_pkg::CLINT);
  assign clint_bus.araddr  = addr_q;
  assign clint_bus.rready  = (state_q == soc_bus_pkg::RD_DATA) &&
                             (target_q == soc_bus_pkg::CLINT);

  // serial port is write only
  assign uart_bus.awvalid = (state_q == soc_bus_pkg::WR_ADDR) && aw_pend_q &&
                            (target_q == soc_bus_pkg::UART);
  assign uart_bus.awaddr  = addr_q;
  assign uart_bus.wvalid  = (state_q == soc_bus_pkg::WR_ADDR) && w_pend_q &&
                            (target_q == soc_bus_pkg::UART);
  assign uart_bus.wdata   = wdata_q;
  assign uart_bus.wstrb   = wstrb_q;
  assign uart_bus.bready  = (state_q == soc_bus_pkg::WR_RESP) &&
                            (target_q == soc_bus_pkg::UART);
  assign uart_bus.arvalid = 1'b0;
  assign uart_bus.araddr  = '0;
  assign uart_bus.rready  = 1'b0;

  // front-end results, data and error are qualified by the pulses
  assign ifu_rdata_o  = rdata_q;
  assign ifu_rvalid_o = ifu_done_q;
  assign ifu_err_o    = err_q;
  assign lsu_rdata_o  = rdata_q;
  assign lsu_rvalid_o = lsu_rd_done_q;
  assign lsu_wready_o = lsu_wr_done_q;
  assign lsu_err_o    = err_q;

endmodule

// File: hdl/clint_timer.sv
`timescale 1ns/1ns
`include "soc_bus_settings.svh"

module clint_timer (
  input  logic       clk,
  input  logic       rst,
  axi_lite_if.slave  bus
);

  logic [2*`SOC_BUS_DATA_W-1:0]  mtime_q;
  logic [7:0]                    div_q;
  logic                          tick;
  logic [`SOC_BUS_DATA_W-1:0]    snap_hi_q;
  logic [`SOC_BUS_DATA_W-1:0]    rdata_q;
  logic                          rvalid_q;

  assign tick = (div_q == 8'(`SOC_BUS_MTIME_DIV - 1));

  // free-running mtime prescaler and counter
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      div_q   <= '0;
      mtime_q <= '0;
    end
    else
    begin
      div_q <= tick ? '0 : div_q + 8'd1;
      if (tick)
        mtime_q <= mtime_q + 1'b1;
    end
  end

  // one read in flight, response one cycle after ar
  always_ff @(posedge clk)
  begin
    if (rst)
      rvalid_q <= 1'b0;
    else if (bus.arvalid)
      rvalid_q <= 1'b1;
    else if (bus.rready)
      rvalid_q <= 1'b0;
  end

  // low word read freezes the high word for the following read
  always_ff @(posedge clk)
  begin
    if (bus.arvalid)
    begin
      if (bus.araddr == `SOC_BUS_RTC_ADDR)
      begin
        rdata_q   <= mtime_q[`SOC_BUS_DATA_W-1:0];
        snap_hi_q <= mtime_q[2*`SOC_BUS_DATA_W-1:`SOC_BUS_DATA_W];
      end
      else
        rdata_q <= snap_hi_q;
    end
  end

  assign bus.arready = 1'b1;
  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign bus.rresp   = soc_bus_pkg::OKAY;

  // no writable registers
  assign bus.awready = 1'b0;
  assign bus.wready  = 1'b0;
  assign bus.bvalid  = 1'b0;
  assign bus.bresp   = soc_bus_pkg::OKAY;

endmodule

// File: hdl/uart_tx_port.sv
`timescale 1ns/1ns
`include "soc_bus_settings.svh"

module uart_tx_port (
  input  logic       clk,
  input  logic       rst,
  axi_lite_if.slave  bus,
  output logic       uart_txd_o
);

  logic        busy_q;
  logic        bvalid_q;
  logic        txd_q;
  logic [8:0]  shift_q;
  logic [3:0]  bit_q;
  logic [7:0]  div_q;
  logic        bit_end;
  logic        idle;
  logic        wr_hs;

  assign bit_end = (div_q == 8'(`SOC_BUS_UART_DIV - 1));

  // take aw and w together, only with the line free and no response pending
  assign idle  = !busy_q && !bvalid_q;
  assign wr_hs = idle && bus.awvalid && bus.wvalid;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_q   <= 1'b0;
      bvalid_q <= 1'b0;
      txd_q    <= 1'b1;
      bit_q    <= '0;
      div_q    <= '0;
    end
    else
    begin
      if (wr_hs)
        bvalid_q <= 1'b1;
      else if (bus.bready)
        bvalid_q <= 1'b0;

      if (wr_hs)
      begin
        // start bit goes out right away
        busy_q <= 1'b1;
        txd_q  <= 1'b0;
        bit_q  <= '0;
        div_q  <= '0;
      end
      else if (busy_q)
      begin
        div_q <= bit_end ? '0 : div_q + 8'd1;
        if (bit_end)
        begin
          if (bit_q == 4'd9)
            busy_q <= 1'b0;
          else
          begin
            txd_q <= shift_q[0];
            bit_q <= bit_q + 4'd1;
          end
        end
      end
    end
  end

  // data bits lsb first, then the stop bit shifted in from the top
  always_ff @(posedge clk)
  begin
    if (wr_hs)
      shift_q <= {1'b1, bus.wdata[7:0]};
    else if (busy_q && bit_end)
      shift_q <= {1'b1, shift_q[8:1]};
  end

  assign uart_txd_o  = txd_q;

  assign bus.awready = wr_hs;
  assign bus.wready  = wr_hs;
  assign bus.bvalid  = bvalid_q;
  assign bus.bresp   = soc_bus_pkg::OKAY;

  // transmit only
  assign bus.arready = 1'b0;
  assign bus.rvalid  = 1'b0;
  assign bus.rdata   = '0;
  assign bus.rresp   = soc_bus_pkg::OKAY;

endmodule

// File: hdl/soc_bus_top.sv
`timescale 1ns/1ns
`include "soc_bus_settings.svh"

module soc_bus_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [`SOC_BUS_ADDR_W-1:0]    ifu_araddr_i,
  input  logic                          ifu_arvalid_i,
  input  logic [`SOC_BUS_ADDR_W-1:0]    lsu_araddr_i,
  input  logic                          lsu_arvalid_i,
  input  logic [`SOC_BUS_ADDR_W-1:0]    lsu_awaddr_i,
  input  logic [`SOC_BUS_DATA_W-1:0]    lsu_wdata_i,
  input  logic [`SOC_BUS_DATA_W/8-1:0]  lsu_wstrb_i,
  input  logic                          lsu_wvalid_i,
  output logic [`SOC_BUS_DATA_W-1:0]    ifu_rdata_o,
  output logic                          ifu_rvalid_o,
  output logic                          ifu_err_o,
  output logic [`SOC_BUS_DATA_W-1:0]    lsu_rdata_o,
  output logic                          lsu_rvalid_o,
  output logic                          lsu_wready_o,
  output logic                          lsu_err_o,
  output logic [`SOC_BUS_ADDR_W-1:0]    m_awaddr_o,
  output logic                          m_awvalid_o,
  input  logic                          m_awready_i,
  output logic [`SOC_BUS_DATA_W-1:0]    m_wdata_o,
  output logic [`SOC_BUS_DATA_W/8-1:0]  m_wstrb_o,
  output logic                          m_wvalid_o,
  input  logic                          m_wready_i,
  input  logic [1:0]                    m_bresp_i,
  input  logic                          m_bvalid_i,
  output logic                          m_bready_o,
  output logic [`SOC_BUS_ADDR_W-1:0]    m_araddr_o,
  output logic                          m_arvalid_o,
  input  logic                          m_arready_i,
  input  logic [`SOC_BUS_DATA_W-1:0]    m_rdata_i,
  input  logic [1:0]                    m_rresp_i,
  input  logic                          m_rvalid_i,
  output logic                          m_rready_o,
  output logic                          uart_txd_o
);

  axi_lite_if ext_bus ();
  axi_lite_if clint_bus ();
  axi_lite_if uart_bus ();

  // external port onto the plain m_ pins
  assign m_awaddr_o      = ext_bus.awaddr;
  assign m_awvalid_o     = ext_bus.awvalid;
  assign ext_bus.awready = m_awready_i;
  assign m_wdata_o       = ext_bus.wdata;
  assign m_wstrb_o       = ext_bus.wstrb;
  assign m_wvalid_o      = ext_bus.wvalid;
  assign ext_bus.wready  = m_wready_i;
  assign ext_bus.bresp   = m_bresp_i;
  assign ext_bus.bvalid  = m_bvalid_i;
  assign m_bready_o      = ext_bus.bready;
  assign m_araddr_o      = ext_bus.araddr;
  assign m_arvalid_o     = ext_bus.arvalid;
  assign ext_bus.arready = m_arready_i;
  assign ext_bus.rdata   = m_rdata_i;
  assign ext_bus.rresp   = m_rresp_i;
  assign ext_bus.rvalid  = m_rvalid_i;
  assign m_rready_o      = ext_bus.rready;

  bus_arbiter u_arbiter (
    .clk           (clk),
    .rst           (rst),
    .ifu_araddr_i  (ifu_araddr_i),
    .ifu_arvalid_i (ifu_arvalid_i),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .lsu_wvalid_i  (lsu_wvalid_i),
    .ifu_rdata_o   (ifu_rdata_o),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .ifu_err_o     (ifu_err_o),
    .lsu_rdata_o   (lsu_rdata_o),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_wready_o  (lsu_wready_o),
    .lsu_err_o     (lsu_err_o),
    .ext           (ext_bus.master),
    .clint_bus     (clint_bus.master),
    .uart_bus      (uart_bus.master)
  );

  clint_timer u_clint (
    .clk (clk),
    .rst (rst),
    .bus (clint_bus.slave)
  );

  uart_tx_port u_uart (
    .clk        (clk),
    .rst        (rst),
    .bus        (uart_bus.slave),
    .uart_txd_o (uart_txd_o)
  );

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o
);

  // 100 ns period
  initial
  begin
    clk_o = 1'b0;
    forever
      #50 clk_o = ~clk_o;
  end

endmodule

// File: verif/soc_bus_props.sv
`timescale 1ns/1ns
`include "soc_bus_settings.svh"

module soc_bus_props (
  input logic                          clk,
  input logic                          rst,
  input logic [`SOC_BUS_ADDR_W-1:0]    m_awaddr_o,
  input logic                          m_awvalid_o,
  input logic                          m_awready_i,
  input logic [`SOC_BUS_DATA_W-1:0]    m_wdata_o,
  input logic [`SOC_BUS_DATA_W/8-1:0]  m_wstrb_o,
  input logic                          m_wvalid_o,
  input logic                          m_wready_i,
  input logic [`SOC_BUS_ADDR_W-1:0]    m_araddr_o,
  input logic                          m_arvalid_o,
  input logic                          m_arready_i
);

  // valid holds with a stable payload until ready
  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o))
    else $error("ar channel dropped or changed before arready");

  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    m_awvalid_o && !m_awready_i |=> m_awvalid_o && $stable(m_awaddr_o))
    else $error("aw channel dropped or changed before awready");

  a_w_hold: assert property (@(posedge clk) disable iff (rst)
    m_wvalid_o && !m_wready_i |=> m_wvalid_o && $stable(m_wdata_o) && $stable(m_wstrb_o))
    else $error("w channel dropped or changed before wready");

  // one transaction in flight
  a_one_dir: assert property (@(posedge clk) disable iff (rst)
    !(m_arvalid_o && m_awvalid_o))
    else $error("read and write address valid together");

  a_rst_quiet: assert property (@(posedge clk)
    rst |=> !m_arvalid_o && !m_awvalid_o && !m_wvalid_o)
    else $error("external valid raised during reset");

endmodule

bind soc_bus_top soc_bus_props u_props (
  .clk         (clk),
  .rst         (rst),
  .m_awaddr_o  (m_awaddr_o),
  .m_awvalid_o (m_awvalid_o),
  .m_awready_i (m_awready_i),
  .m_wdata_o   (m_wdata_o),
  .m_wstrb_o   (m_wstrb_o),
  .m_wvalid_o  (m_wvalid_o),
  .m_wready_i  (m_wready_i),
  .m_araddr_o  (m_araddr_o),
  .m_arvalid_o (m_arvalid_o),
  .m_arready_i (m_arready_i)
);

// File: verif/tb_soc_bus.sv
`timescale 1ns/1ns
`include "soc_bus_settings.svh"

module tb_soc_bus;

  localparam int N_IFU  = 16;
  localparam int N_ST   = 12;
  localparam int N_PAIR = 6;
  localparam int N_UART = 4;
  localparam int N_TMR  = 5;
  localparam int N_ERR  = 4;
  localparam int TXN_TOTAL = N_IFU + 2*N_ST + 2*N_PAIR + N_UART + 2*N_TMR + 4*N_ERR;
  // worst case per transaction plus serial frames and timer gaps
  localparam longint WD_CYCLES = 20 + TXN_TOTAL*60 +
                                 N_UART*24*`SOC_BUS_UART_DIV + N_TMR*16;
  localparam logic [31:0] ERR_BASE = 32'hF000_0000;

  logic clk, rst;
  logic [31:0] ifu_araddr, lsu_araddr, lsu_awaddr, lsu_wdata;
  logic [3:0]  lsu_wstrb;
  logic        ifu_arvalid, lsu_arvalid, lsu_wvalid;
  logic [31:0] ifu_rdata_o, lsu_rdata_o, m_awaddr_o, m_wdata_o, m_araddr_o, m_rdata;
  logic        ifu_rvalid_o, ifu_err_o, lsu_rvalid_o, lsu_wready_o, lsu_err_o;
  logic [3:0]  m_wstrb_o;
  logic        m_awvalid_o, m_wvalid_o, m_bready_o, m_arvalid_o, m_rready_o, uart_txd_o;
  logic        m_awready, m_wready, m_bvalid, m_arready, m_rvalid;
  logic [1:0]  m_bresp, m_rresp;

  logic [31:0] slave_mem [logic [31:0]];
  logic [31:0] exp_mem [logic [31:0]];
  // {skip data, err, data}
  logic [33:0] ifu_exp_q [$];
  logic [33:0] lsu_rd_exp_q [$];
  logic        lsu_wr_exp_q [$];
  logic [7:0]  uart_exp_q [$];
  logic [7:0]  uart_rx_q [$];
  logic [31:0] ar_addr_q [$];
  logic [33:0] e_ifu, e_lsu;
  int cyc, errs, checks, tests, test_errs, ar_count, aw_count;
  int cl, base, k, i, lat, t_prev, t_now;
  logic [31:0] a1, a2, lo, hi;
  logic [63:0] v, v_prev;
  int unsigned seed_val;

  tb_clk_gen u_clk (.clk_o(clk));

  soc_bus_top u_dut (
    .clk (clk), .rst (rst),
    .ifu_araddr_i (ifu_araddr), .ifu_arvalid_i (ifu_arvalid),
    .lsu_araddr_i (lsu_araddr), .lsu_arvalid_i (lsu_arvalid),
    .lsu_awaddr_i (lsu_awaddr), .lsu_wdata_i (lsu_wdata),
    .lsu_wstrb_i (lsu_wstrb), .lsu_wvalid_i (lsu_wvalid),
    .ifu_rdata_o (ifu_rdata_o), .ifu_rvalid_o (ifu_rvalid_o), .ifu_err_o (ifu_err_o),
    .lsu_rdata_o (lsu_rdata_o), .lsu_rvalid_o (lsu_rvalid_o),
    .lsu_wready_o (lsu_wready_o), .lsu_err_o (lsu_err_o),
    .m_awaddr_o (m_awaddr_o), .m_awvalid_o (m_awvalid_o), .m_awready_i (m_awready),
    .m_wdata_o (m_wdata_o), .m_wstrb_o (m_wstrb_o), .m_wvalid_o (m_wvalid_o),
    .m_wready_i (m_wready), .m_bresp_i (m_bresp), .m_bvalid_i (m_bvalid),
    .m_bready_o (m_bready_o), .m_araddr_o (m_araddr_o), .m_arvalid_o (m_arvalid_o),
    .m_arready_i (m_arready), .m_rdata_i (m_rdata), .m_rresp_i (m_rresp),
    .m_rvalid_i (m_rvalid), .m_rready_o (m_rready_o), .uart_txd_o (uart_txd_o)
  );

  always @(posedge clk)
    cyc <= cyc + 1;

  // unwritten memory content depends on every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'h5A5A_0F0F;
  endfunction

  function automatic logic [31:0] merge_strb(input logic [31:0] old_w, input logic [31:0] new_w,
                                             input logic [3:0] strb);
    logic [31:0] r;
    int b;
    r = old_w;
    for (b = 0; b < 4; b++)
      if (strb[b])
        r[8*b +: 8] = new_w[8*b +: 8];
    return r;
  endfunction

  // shadow memory word as the bus should see it
  function automatic logic [31:0] shadow_word(input logic [31:0] a);
    return exp_mem.exists(a) ? exp_mem[a] : fill_word(a);
  endfunction

  // expected {err, data} of an external load
  function automatic logic [32:0] ref_read(input logic [31:0] a);
    if (a >= ERR_BASE)
      return {1'b1, 32'h0};
    return {1'b0, shadow_word(a)};
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("ERR %s got %h exp %h", name, got, exp);
      errs++;
    end
  endtask

  task automatic note_failure(input string what);
    $display("%s", what);
    errs++;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errs - test_errs);
    test_errs = errs;
  endtask

  task automatic ifu_read(input logic [31:0] a);
    @(negedge clk);
    ifu_araddr  = a;
    ifu_arvalid = 1'b1;
    ifu_exp_q.push_back({1'b0, ref_read(a)});
    do
      @(negedge clk);
    while (!ifu_rvalid_o);
    ifu_arvalid = 1'b0;
  endtask

  task automatic lsu_load(input logic [31:0] a, input logic skip, output int done_cyc);
    @(negedge clk);
    lsu_araddr  = a;
    lsu_arvalid = 1'b1;
    lsu_rd_exp_q.push_back(skip ? {2'b10, 32'h0} : {1'b0, ref_read(a)});
    done_cyc = cyc;
    do
      @(negedge clk);
    while (!lsu_rvalid_o);
    done_cyc    = cyc - done_cyc;
    lsu_arvalid = 1'b0;
  endtask

  task automatic lsu_store(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    @(negedge clk);
    lsu_awaddr = a;
    lsu_wdata  = d;
    lsu_wstrb  = s;
    lsu_wvalid = 1'b1;
    lsu_wr_exp_q.push_back(a >= ERR_BASE);
    if (a == `SOC_BUS_SERIAL_ADDR)
      uart_exp_q.push_back(d[7:0]);
    else if (a < ERR_BASE)
      exp_mem[a] = merge_strb(shadow_word(a), d, s);
    do
      @(negedge clk);
    while (!lsu_wready_o);
    lsu_wvalid = 1'b0;
  endtask

  // compare every done pulse with the queued expectation
  always @(negedge clk)
  begin
    if (ifu_rvalid_o)
    begin
      assert (ifu_exp_q.size() > 0)
      else
        note_failure("ifu done pulse with no request pending");
      if (ifu_exp_q.size() > 0)
      begin
        e_ifu = ifu_exp_q.pop_front();
        check_val("ifu_err_o", ifu_err_o, e_ifu[32]);
        if (!e_ifu[32] && !e_ifu[33])
          check_val("ifu_rdata_o", ifu_rdata_o, e_ifu[31:0]);
      end
    end
    if (lsu_rvalid_o)
    begin
      assert (lsu_rd_exp_q.size() > 0)
      else
        note_failure("lsu load done pulse with no request pending");
      if (lsu_rd_exp_q.size() > 0)
      begin
        e_lsu = lsu_rd_exp_q.pop_front();
        check_val("lsu_err_o", lsu_err_o, e_lsu[32]);
        if (!e_lsu[32] && !e_lsu[33])
          check_val("lsu_rdata_o", lsu_rdata_o, e_lsu[31:0]);
      end
    end
    if (lsu_wready_o)
    begin
      assert (lsu_wr_exp_q.size() > 0)
      else
        note_failure("lsu store done pulse with no request pending");
      if (lsu_wr_exp_q.size() > 0)
        check_val("lsu_err_o", lsu_err_o, lsu_wr_exp_q.pop_front());
    end
  end

  // external read slave
  initial
  begin : rd_slave
    logic [31:0] a;
    m_arready = 1'b0;
    m_rvalid  = 1'b0;
    m_rdata   = '0;
    m_rresp   = 2'd0;
    forever
    begin
      @(negedge clk);
      if (!rst && m_arvalid_o)
      begin
        a = m_araddr_o;
        repeat ($urandom_range(3)) @(negedge clk);
        m_arready = 1'b1;
        @(negedge clk);
        m_arready = 1'b0;
        ar_count++;
        ar_addr_q.push_back(a);
        while (!m_rready_o)
          @(negedge clk);
        repeat ($urandom_range(3)) @(negedge clk);
        m_rresp  = (a >= ERR_BASE) ? 2'd2 : 2'd0;
        m_rdata  = (a >= ERR_BASE) ? 32'h0 :
                   (slave_mem.exists(a) ? slave_mem[a] : fill_word(a));
        m_rvalid = 1'b1;
        @(negedge clk);
        m_rvalid = 1'b0;
      end
    end
  end

  // external write slave accepting aw and w with separate delays
  initial
  begin : wr_slave
    logic [31:0] a, wd, old_w;
    logic [3:0]  ws;
    int da, dw, c, b;
    m_awready = 1'b0;
    m_wready  = 1'b0;
    m_bvalid  = 1'b0;
    m_bresp   = 2'd0;
    forever
    begin
      @(negedge clk);
      if (!rst && m_awvalid_o && m_wvalid_o)
      begin
        a  = m_awaddr_o;
        wd = m_wdata_o;
        ws = m_wstrb_o;
        da = $urandom_range(3);
        dw = $urandom_range(3);
        c  = 0;
        while (c <= da || c <= dw)
        begin
          m_awready = (c == da);
          m_wready  = (c == dw);
          @(negedge clk);
          c++;
        end
        m_awready = 1'b0;
        m_wready  = 1'b0;
        aw_count++;
        if (a < ERR_BASE)
        begin
          old_w = slave_mem.exists(a) ? slave_mem[a] : fill_word(a);
          for (b = 0; b < 4; b++)
            if (ws[b])
              old_w[8*b +: 8] = wd[8*b +: 8];
          slave_mem[a] = old_w;
        end
        while (!m_bready_o)
          @(negedge clk);
        repeat ($urandom_range(3)) @(negedge clk);
        m_bresp  = (a >= ERR_BASE) ? 2'd2 : 2'd0;
        m_bvalid = 1'b1;
        @(negedge clk);
        m_bvalid = 1'b0;
      end
    end
  end

  // 8N1 decoder sampling mid bit
  initial
  begin : uart_rx
    logic [7:0] rx;
    int n;
    forever
    begin
      @(negedge clk);
      if (!rst && uart_txd_o === 1'b0)
      begin
        repeat (`SOC_BUS_UART_DIV/2) @(negedge clk);
        assert (uart_txd_o === 1'b0)
        else
          note_failure("serial start bit shorter than half a bit");
        for (n = 0; n < 8; n++)
        begin
          repeat (`SOC_BUS_UART_DIV) @(negedge clk);
          rx[n] = uart_txd_o;
        end
        repeat (`SOC_BUS_UART_DIV) @(negedge clk);
        assert (uart_txd_o === 1'b1)
        else
          note_failure("serial stop bit missing");
        uart_rx_q.push_back(rx);
      end
    end
  end

  initial
  begin : watchdog
    #(WD_CYCLES * 100);
    $display("watchdog expired after %0d cycles, a transaction never completed", WD_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial
  begin
    seed_val    = $urandom(98349);
    rst         = 1'b1;
    ifu_araddr  = '0;
    ifu_arvalid = 1'b0;
    lsu_araddr  = '0;
    lsu_arvalid = 1'b0;
    lsu_awaddr  = '0;
    lsu_wdata   = '0;
    lsu_wstrb   = '0;
    lsu_wvalid  = 1'b0;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    for (i = 0; i < N_IFU; i++)
      ifu_read(32'h8000_0000 | ($urandom & 32'h0FFF_FFFC));
    end_test("ifu external reads");

    for (i = 0; i < N_ST; i++)
    begin
      a1 = 32'h8000_1000 + 32'($urandom_range(7) << 2);
      lsu_store(a1, $urandom, 4'($urandom));
      lsu_load(a1, 1'b0, cl);
    end
    end_test("lsu strobed stores and loads");

    for (i = 0; i < N_PAIR; i++)
    begin
      a1 = 32'h8000_0000 | ($urandom & 32'h0000_FFFC);
      a2 = 32'h8100_0000 | ($urandom & 32'h0000_FFFC);
      base = ar_count;
      ar_addr_q.delete();
      fork
        ifu_read(a1);
        lsu_load(a2, 1'b0, cl);
      join
      assert (ar_count - base == 2)
      else
        note_failure("simultaneous reads did not appear exactly once each on m_arvalid_o");
      if (ar_count - base == 2)
      begin
        check_val("m_araddr_o", ar_addr_q[0], a2);
        check_val("m_araddr_o", ar_addr_q[1], a1);
      end
    end
    end_test("ifu and lsu in the same cycle");

    base = aw_count;
    for (i = 0; i < N_UART; i++)
      lsu_store(`SOC_BUS_SERIAL_ADDR, {24'h0, 8'($urandom)}, 4'h1);
    k = 0;
    while (uart_rx_q.size() < N_UART && k < 12 * `SOC_BUS_UART_DIV * N_UART)
    begin
      @(negedge clk);
      k++;
    end
    assert (uart_rx_q.size() >= N_UART)
    else
      note_failure("serial frames missing on uart_txd_o");
    if (uart_rx_q.size() >= N_UART)
      for (i = 0; i < N_UART; i++)
        check_val("uart_txd_o byte", uart_rx_q[i], uart_exp_q[i]);
    assert (aw_count == base)
    else
      note_failure("serial store leaked onto m_awvalid_o");
    end_test("serial stores");

    base = ar_count;
    v_prev = '0;
    t_prev = 0;
    for (i = 0; i < N_TMR; i++)
    begin
      repeat ($urandom_range(15)) @(negedge clk);
      t_now = cyc + 1;
      lsu_load(`SOC_BUS_RTC_ADDR, 1'b1, lat);
      lo = lsu_rdata_o;
      check_val("lsu_rvalid_o latency", lat, 3);
      lsu_load(`SOC_BUS_RTC_ADDR_UP, 1'b1, lat);
      hi = lsu_rdata_o;
      check_val("lsu_rvalid_o latency", lat, 3);
      v = {hi, lo};
      if (i > 0)
      begin
        assert (v >= v_prev)
        else
          note_failure("mtime went backwards between reads");
        assert (v < v_prev ||
                longint'(v - v_prev) >= longint'((t_now - t_prev) / `SOC_BUS_MTIME_DIV - 1))
        else
          note_failure("mtime advanced less than the elapsed cycles allow");
      end
      v_prev = v;
      t_prev = t_now;
    end
    assert (ar_count == base)
    else
      note_failure("timer read reached m_arvalid_o");
    end_test("timer reads");

    for (i = 0; i < N_ERR; i++)
    begin
      a1 = ERR_BASE | ($urandom & 32'h0FFF_FFFC);
      lsu_store(a1, $urandom, 4'hF);
      lsu_load(a1, 1'b0, cl);
      lsu_load(32'h8000_2000 | ($urandom & 32'h0000_0FFC), 1'b0, cl);
      ifu_read(a1);
    end
    end_test("error responses");

    repeat (4) @(negedge clk);
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errs);
    if (errs == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: src.f
+incdir+include
hdl/soc_bus_pkg.sv
hdl/axi_lite_if.sv
hdl/bus_arbiter.sv
hdl/clint_timer.sv
hdl/uart_tx_port.sv
hdl/soc_bus_top.sv
verif/tb_clk_gen.sv
verif/soc_bus_props.sv
verif/tb_soc_bus.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the bus testbench with Verilator.
set -u

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_soc_bus -f src.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
